// File: design/cart_cfg.svh
// Cartridge loader configuration
// Header offsets, field widths and default codes shared by the loader blocks

`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// Copier header in front of the image
`define CART_HDR_SKIP 24'h000200

// Byte address of the ROM size field in each memory map
// The RAM size field follows two bytes later
`define LOROM_HDR_ADDR 24'h007FD6
`define HIROM_HDR_ADDR 24'h00FFD6
`define EXHIROM_HDR_ADDR 24'h40FFD6

// Size code used when the image gives none
`define DEFAULT_ROM_SIZE 4'hC

// Widths
`define MASK_W 24
`define DL_ADDR_W 25
`define CLEAR_AW 17

// 512-byte sectors on the backup image
`define SECTOR_SHIFT 9

// Download index that carries cheat data
`define CODE_INDEX 8'd255

`endif

// File: design/cart_pkg.sv
// Cartridge loader types
// Download word, menu options, cartridge configuration, sector request
// and the cheat code layout

`default_nettype none

`include "cart_cfg.svh"

package cart_pkg;

	// One word of the download stream
	typedef struct packed {
		logic                    active;
		logic [7:0]              index;
		logic [`DL_ADDR_W-1:0]   addr;
		logic [15:0]             data;
		logic                    wr;
	} dl_word_t;

	// Menu settings
	typedef struct packed {
		logic [2:0] map_sel;     // 0 auto, 1 no header, 2 LoROM, 3 HiROM, 4 ExHiROM
		logic [1:0] region_sel;  // 0 auto, 1 NTSC, 2 PAL
		logic [1:0] wram_fill;
		logic       autosave;
		logic       menu_reset;
	} cart_opts_t;

	// Detected cartridge configuration
	typedef struct packed {
		logic [7:0]           rom_type;
		logic [`MASK_W-1:0]   rom_mask;
		logic [`MASK_W-1:0]   ram_mask;
		logic                 pal;
	} cart_cfg_t;

	// Sector request towards the image
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Decoded cheat, values in big endian byte order
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// word[k/2][k%2] is the k-th word of the download, low half first
	typedef union packed {
		logic [0:3][1:0][15:0] word;
		cheat_fields_t         field;
	} cheat_code_u;

endpackage

`default_nettype wire

// File: design/cart_header_detect.sv
// Cartridge header detector
// Picks ROM type, size codes and region out of the downloaded image and
// holds the resulting configuration for the rest of the core

`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module cart_header_detect (
	input  wire                   clk_sys,
	input  wire                   RESET,
	input  cart_pkg::dl_word_t    dl,
	input  wire                   cart_dl,
	input  cart_pkg::cart_opts_t  opts,
	output cart_pkg::cart_cfg_t   cfg
);

	localparam logic [`DL_ADDR_W-1:0] LO_FIELD = `LOROM_HDR_ADDR + `CART_HDR_SKIP;
	localparam logic [`DL_ADDR_W-1:0] HI_FIELD = `HIROM_HDR_ADDR + `CART_HDR_SKIP;
	localparam logic [`DL_ADDR_W-1:0] EX_FIELD = `EXHIROM_HDR_ADDR + `CART_HDR_SKIP;
	localparam logic [`MASK_W-1:0]    MASK_BASE = 1024;

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    rom_region;
	logic [`DL_ADDR_W-1:0]   hdr_base;
	logic                    hdr_sel;
	logic                    wr_en;

	assign wr_en = cart_dl & dl.wr;

	// Size field location for a forced memory map
	always_comb begin
		hdr_sel = 1'b1;
		case (opts.map_sel)
			3'd2: hdr_base = LO_FIELD;
			3'd3: hdr_base = HI_FIELD;
			3'd4: hdr_base = EX_FIELD;
			default: begin
				hdr_base = '0;
				hdr_sel  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= `DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			cfg        <= '0;
		end else if (cart_dl) begin
			if (wr_en) begin
				if (dl.addr == '0) begin
					rom_size <= `DEFAULT_ROM_SIZE;
					ram_size <= 4'd0;
					if (opts.map_sel == 3'd0 && dl.data[7:0] != 8'd0)
						{ram_size, rom_size} <= dl.data[7:0];
					case (opts.map_sel)
						3'd1, 3'd2: cfg.rom_type <= 8'd0;
						3'd3: cfg.rom_type <= 8'd1;
						3'd4: cfg.rom_type <= 8'd2;
						default: cfg.rom_type <= dl.data[15:8];
					endcase
				end
				if (dl.addr == `DL_ADDR_W'(2))
					rom_region <= dl.data[8];
				// Header of the chosen map overrides the copier header
				if (hdr_sel && dl.addr == hdr_base)
					rom_size <= dl.data[11:8];
				if (hdr_sel && dl.addr == hdr_base + 2'd2)
					ram_size <= dl.data[3:0];

				// Masks follow the codes held before this write
				cfg.rom_mask <= (MASK_BASE << rom_size) - 1'b1;
				cfg.ram_mask <= (ram_size != 4'd0) ? (MASK_BASE << ram_size) - 1'b1 : '0;
			end
		end else begin
			cfg.pal <= (opts.region_sel == 2'd0) ? rom_region : opts.region_sel[1];
		end
	end

endmodule

`default_nettype wire

// File: design/cheat_code_loader.sv
// Cheat code loader
// Collects eight 16-bit download words into one code and strobes it out

`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader (
	input  wire                   clk_sys,
	input  wire                   RESET,
	input  cart_pkg::dl_word_t    dl,
	input  wire                   code_dl,
	output cart_pkg::cheat_code_u code,
	output logic                  code_valid
);

	logic [2:0] slot;
	logic       word_wr;

	// Words sit on even byte addresses
	assign slot    = dl.addr[3:1];
	assign word_wr = code_dl & dl.wr & ~dl.addr[0];

	// Code storage
	always_ff @(posedge clk_sys) begin
		if (word_wr)
			code.word[slot[2:1]][slot[0]] <= dl.data;
	end

	// Last word of a code, replace top half
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= word_wr & (slot == 3'd7);
	end

endmodule

`default_nettype wire

// File: design/ram_clear.sv
// Work RAM clear
// Walks the whole work RAM once at the start of a cartridge download and
// supplies the power-on fill pattern selected in the menu

`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module ram_clear (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     cart_dl,
	input  wire  [1:0]              wram_fill,
	output logic                    clearing,
	output logic [`CLEAR_AW-1:0]    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_wr
);

	logic dl_q;
	logic dl_rise;

	assign dl_rise = cart_dl & ~dl_q;
	assign fill_wr = clearing;

	// ========================================================================
	// Address sweep
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			dl_q <= cart_dl;
			if (clearing && &fill_addr)
				clearing <= 1'b0;
			else if (dl_rise)
				clearing <= 1'b1;

			// Idles at zero, wraps back to zero after the last write
			if (clearing)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	// ========================================================================
	// Fill patterns of the different console revisions
	// ========================================================================

	always_comb begin
		case (wram_fill)
			2'd0: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			2'd1: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			2'd2: fill_data = 8'h55;
			default: fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// File: design/backup_ram_sync.sv
// Backup RAM sync
// Sector by sector load and save of the cartridge backup RAM against the
// mounted save image, with autosave of pending writes while the menu is open

`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module backup_ram_sync (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  cart_dl,
	input  wire [`MASK_W-1:0]    ram_mask,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire                  img_has_data,
	input  wire                  osd_open,
	input  wire                  autosave,
	input  wire                  bk_load,
	input  wire                  bk_save,
	input  wire                  bsram_write,
	input  wire                  sd_ack,
	output cart_pkg::sd_req_t    sd,
	output logic                 busy,
	output logic                 loading,
	output logic                 pending
);

	logic        ena;
	logic        dl_q, load_q, save_q, ack_q;
	logic        load_now, save_now;
	logic        load_rise, save_rise, dl_end;
	logic        ack_rise, ack_fall;
	logic        start, start_rd, advance, at_last;
	logic        rd_q, wr_q;
	logic [31:0] lba_q;
	logic [31:0] last_lba;

	// Autosave turns a pending write into a save request once the menu opens
	assign load_now  = bk_load & ena;
	assign save_now  = (bk_save | (pending & osd_open & autosave)) & ena;
	assign load_rise = load_now & ~load_q;
	assign save_rise = save_now & ~save_q;
	assign dl_end    = dl_q & ~cart_dl & img_has_data & ena;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ack_q & ~sd_ack;

	assign start    = ~busy & (load_rise | save_rise | dl_end);
	assign start_rd = load_rise | dl_end;
	assign last_lba = 32'(ram_mask >> `SECTOR_SHIFT);
	assign at_last  = lba_q >= last_lba;
	assign advance  = busy & ack_fall & ~at_last;

	assign sd = '{lba: lba_q, rd: rd_q, wr: wr_q};

	// ========================================================================
	// Sequencer
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q    <= 1'b0;
			load_q  <= 1'b0;
			save_q  <= 1'b0;
			ack_q   <= 1'b0;
			ena     <= 1'b0;
			busy    <= 1'b0;
			loading <= 1'b0;
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			pending <= 1'b0;
		end else begin
			dl_q   <= cart_dl;
			load_q <= load_now;
			save_q <= save_now;
			ack_q  <= sd_ack;

			// Save image is mounted by the end of the download
			if (cart_dl && !dl_q)
				ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				ena <= |ram_mask;

			if (ack_rise) begin
				rd_q <= 1'b0;
				wr_q <= 1'b0;
			end

			if (start) begin
				busy    <= 1'b1;
				loading <= start_rd;
				rd_q    <= start_rd;
				wr_q    <= ~start_rd;
			end else if (busy && ack_fall) begin
				if (at_last) begin
					busy    <= 1'b0;
					loading <= 1'b0;
				end else begin
					rd_q <= loading;
					wr_q <= ~loading;
				end
			end

			if (ena && !osd_open && bsram_write)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// Sector number
	always_ff @(posedge clk_sys) begin
		if (start)
			lba_q <= '0;
		else if (advance)
			lba_q <= lba_q + 1'b1;
	end

endmodule

`default_nettype wire

// File: design/cart_loader_top.sv
// Cartridge loader top
// Splits the download stream into cartridge and cheat data, ties the
// header detector, cheat loader, RAM clear and backup sync together and
// builds the core reset

`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module cart_loader_top (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  cart_pkg::dl_word_t      dl,
	input  cart_pkg::cart_opts_t    opts,
	input  wire                     osd_open,
	input  wire                     bk_load,
	input  wire                     bk_save,
	input  wire                     bsram_write,
	input  wire                     img_mounted,
	input  wire                     img_readonly,
	input  wire                     img_has_data,
	input  wire                     sd_ack,
	output cart_pkg::cart_cfg_t     cfg,
	output cart_pkg::cheat_code_u   code,
	output logic                    code_valid,
	output logic                    clearing,
	output logic [`CLEAR_AW-1:0]    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_wr,
	output cart_pkg::sd_req_t       sd,
	output logic                    bk_busy,
	output logic                    bk_pending,
	output logic                    core_reset
);

	logic cart_dl;
	logic code_dl;
	logic bk_loading;

	// Index 255 carries cheats, everything else is cartridge image
	assign cart_dl = dl.active & (dl.index != `CODE_INDEX);
	assign code_dl = dl.active & (dl.index == `CODE_INDEX);

	// Core stays in reset while its memories are being filled
	assign core_reset = RESET | opts.menu_reset | cart_dl | clearing | bk_loading;

	// ========================================================================
	// Blocks
	// ========================================================================

	cart_header_detect cart_header_detect_inst (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.dl      (dl),
		.cart_dl (cart_dl),
		.opts    (opts),
		.cfg     (cfg)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.code_dl    (code_dl),
		.code       (code),
		.code_valid (code_valid)
	);

	ram_clear ram_clear_inst (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.cart_dl   (cart_dl),
		.wram_fill (opts.wram_fill),
		.clearing  (clearing),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_wr   (fill_wr)
	);

	backup_ram_sync backup_ram_sync_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_dl      (cart_dl),
		.ram_mask     (cfg.ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_has_data (img_has_data),
		.osd_open     (osd_open),
		.autosave     (opts.autosave),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd           (sd),
		.busy         (bk_busy),
		.loading      (bk_loading),
		.pending      (bk_pending)
	);

endmodule

`default_nettype wire

// File: tests/cart_loader_sva.sv
// Backup RAM sequencer checks
// Sector request rules against the image acknowledge

`timescale 1ns/1ps
`default_nettype none

module cart_loader_sva (
	input wire               clk_sys,
	input wire               RESET,
	input wire               sd_ack,
	input wire               busy,
	input cart_pkg::sd_req_t sd
);

	// One direction at a time
	rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (RESET) !(sd.rd && sd.wr)
	) else $error("sector read and write requested together");

	// Requests only inside a transfer
	req_while_busy: assert property (
		@(posedge clk_sys) disable iff (RESET) (sd.rd || sd.wr) |-> busy
	) else $error("sector request outside of a transfer");

	// Acknowledge takes the request away
	req_drop_on_ack: assert property (
		@(posedge clk_sys) disable iff (RESET) $rose(sd_ack) |=> (!sd.rd && !sd.wr)
	) else $error("sector request still high after acknowledge");

endmodule

bind backup_ram_sync cart_loader_sva cart_loader_sva_inst (
	.clk_sys (clk_sys),
	.RESET   (RESET),
	.sd_ack  (sd_ack),
	.busy    (busy),
	.sd      (sd)
);

`default_nettype wire

// File: tests/cart_loader_tb.sv
// Cartridge loader testbench
// Random downloads, cheat codes, memory clear and backup RAM transfers,
// each checked against a model of the loader rules

`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module cart_loader_tb;

	localparam int CLEAR_WORDS = 1 << `CLEAR_AW;

	logic                         clk_sys = 1'b0;
	logic                         RESET;
	cart_pkg::dl_word_t           dl;
	cart_pkg::cart_opts_t         opts;
	logic                         osd_open;
	logic                         bk_load;
	logic                         bk_save;
	logic                         bsram_write;
	logic                         img_mounted;
	logic                         img_readonly;
	logic                         img_has_data;
	logic                         sd_ack;
	cart_pkg::cart_cfg_t          cfg;
	cart_pkg::cheat_code_u        code;
	logic                         code_valid;
	logic                         clearing;
	logic [`CLEAR_AW-1:0]         fill_addr;
	logic [7:0]                   fill_data;
	logic                         fill_wr;
	cart_pkg::sd_req_t            sd;
	logic                         bk_busy;
	logic                         bk_pending;
	logic                         core_reset;

	integer seed;
	integer errors;
	integer test_errors;
	integer tests_run;
	integer tests_failed;
	integer last_sector;
	integer fill;
	string  test_name;

	always #10 clk_sys = ~clk_sys;

	cart_loader_top cart_loader_top_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.opts         (opts),
		.osd_open     (osd_open),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.bsram_write  (bsram_write),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_has_data (img_has_data),
		.sd_ack       (sd_ack),
		.cfg          (cfg),
		.code         (code),
		.code_valid   (code_valid),
		.clearing     (clearing),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_wr      (fill_wr),
		.sd           (sd),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.core_reset   (core_reset)
	);

	// ========================================================================
	// Bookkeeping
	// ========================================================================

	task automatic next_cycle;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			errors = errors + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		errors = errors + 1;
		test_errors = test_errors + 1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test;
		tests_run = tests_run + 1;
		if (test_errors == 0) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	// ========================================================================
	// Models
	// ========================================================================

	// 1 KB shifted by the size code, as a byte address mask
	function automatic logic [`MASK_W-1:0] size_mask(input logic [3:0] size_code);
		logic [31:0] bytes;
		bytes = 32'd1024 << size_code;
		return `MASK_W'(bytes - 32'd1);
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [1:0] sel,
			input logic [`CLEAR_AW-1:0] addr);
		case (sel)
			2'd0: return (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			2'd1: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// ========================================================================
	// Download stream and waits
	// ========================================================================

	task automatic write_word(input logic [`DL_ADDR_W-1:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		next_cycle();
		dl.wr   = 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		dl.active = 1'b1;
		dl.index  = index;
		next_cycle();
	endtask

	// One idle cycle so the sequencer sees the final masks
	task automatic end_download;
		next_cycle();
		dl.active = 1'b0;
	endtask

	task automatic wait_clear_done;
		integer cycles;
		cycles = 0;
		@(negedge clk_sys);
		while (clearing && cycles < CLEAR_WORDS + 16) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
		end
		if (clearing)
			report_failure("memory clear did not finish");
	endtask

	// Image side of a transfer, random latency and acknowledge length
	task automatic serve_sectors(input logic expect_rd, input integer last);
		integer lba;
		integer cycles;
		integer hold;
		for (lba = 0; lba <= last; lba = lba + 1) begin
			cycles = 0;
			@(negedge clk_sys);
			while (!(sd.rd || sd.wr) && cycles < 20) begin
				@(negedge clk_sys);
				cycles = cycles + 1;
			end
			if (!(sd.rd || sd.wr)) begin
				report_failure($sformatf("no sector request came for lba %0d", lba));
				return;
			end
			check("lba", lba, sd.lba);
			check("rd", expect_rd, sd.rd);
			check("wr", !expect_rd, sd.wr);
			check("busy", 1, bk_busy);
			check("core_reset", expect_rd, core_reset);
			next_cycle();
			repeat ($unsigned($random(seed)) % 3)
				next_cycle();
			sd_ack = 1'b1;
			hold = 1 + $unsigned($random(seed)) % 3;
			repeat (hold)
				next_cycle();
			check("request during ack", 0, {sd.rd, sd.wr});
			sd_ack = 1'b0;
		end
		cycles = 0;
		@(negedge clk_sys);
		while (bk_busy && cycles < 20) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
		end
		if (bk_busy)
			report_failure("backup transfer did not end");
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic header_round;
		logic [31:0]           r;
		logic [2:0]            map;
		logic [1:0]            region;
		logic [15:0]           d0;
		logic [15:0]           d2;
		logic [15:0]           dh;
		logic [15:0]           dh2;
		logic [`DL_ADDR_W-1:0] hdr;
		logic [3:0]            rom_c;
		logic [3:0]            ram_c;
		logic [7:0]            rom_type;
		next_cycle();
		r = $random(seed);
		map = r[2:0];
		region = r[4:3];
		r = $random(seed);
		d0 = r[15:0];
		d2 = r[31:16];
		r = $random(seed);
		dh = r[15:0];
		dh2 = r[31:16];
		opts.map_sel = map;
		opts.region_sel = region;
		case (map)
			3'd3: hdr = `HIROM_HDR_ADDR + `CART_HDR_SKIP;
			3'd4: hdr = `EXHIROM_HDR_ADDR + `CART_HDR_SKIP;
			default: hdr = `LOROM_HDR_ADDR + `CART_HDR_SKIP;
		endcase

		begin_download({1'b0, r[6:0]});
		write_word(`DL_ADDR_W'(0), d0);
		write_word(`DL_ADDR_W'(2), d2);
		write_word(hdr, dh);
		write_word(hdr + `DL_ADDR_W'(2), dh2);
		write_word(`DL_ADDR_W'(4), r[31:16]);
		end_download();
		wait_clear_done();

		// Expected configuration
		rom_c = `DEFAULT_ROM_SIZE;
		ram_c = 4'd0;
		if (map == 3'd0 && d0[7:0] != 8'd0) begin
			rom_c = d0[3:0];
			ram_c = d0[7:4];
		end
		case (map)
			3'd1, 3'd2: rom_type = 8'd0;
			3'd3: rom_type = 8'd1;
			3'd4: rom_type = 8'd2;
			default: rom_type = d0[15:8];
		endcase
		if (map >= 3'd2 && map <= 3'd4) begin
			rom_c = dh[11:8];
			ram_c = dh2[3:0];
		end
		check("rom_type", rom_type, cfg.rom_type);
		check("rom_mask", size_mask(rom_c), cfg.rom_mask);
		check("ram_mask", (ram_c == 4'd0) ? '0 : size_mask(ram_c), cfg.ram_mask);
		check("pal", (region == 2'd0) ? d2[8] : region[1], cfg.pal);
	endtask

	task automatic cheat_round;
		logic [31:0] r;
		logic [15:0] words [0:7];
		integer      k;
		integer      cycles;
		next_cycle();
		dl.active = 1'b1;
		dl.index  = `CODE_INDEX;
		for (k = 0; k < 8; k = k + 1) begin
			r = $random(seed);
			words[k] = r[15:0];
			write_word(`DL_ADDR_W'(2 * k), words[k]);
			if (k < 7)
				check("early code_valid", 0, code_valid);
		end
		dl.active = 1'b0;
		cycles = 0;
		@(negedge clk_sys);
		while (!code_valid && cycles < 8) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
		end
		if (!code_valid) begin
			report_failure("code_valid never came");
			return;
		end
		// Each field is two words, the earlier one in the low half
		check("flags", {words[1], words[0]}, code.field.flags);
		check("address", {words[3], words[2]}, code.field.address);
		check("compare", {words[5], words[4]}, code.field.compare);
		check("replace", {words[7], words[6]}, code.field.replace);
		@(negedge clk_sys);
		check("code_valid width", 0, code_valid);
	endtask

	task automatic clear_round(input logic [1:0] sel);
		integer count;
		integer cycles;
		next_cycle();
		opts.wram_fill = sel;
		begin_download(8'd1);
		dl.active = 1'b0;
		count = 0;
		cycles = 0;
		@(negedge clk_sys);
		check("clearing", 1, clearing);
		while (clearing && cycles < CLEAR_WORDS + 16) begin
			if (test_errors == 0) begin
				check("fill_wr", 1, fill_wr);
				check("fill_addr", count, fill_addr);
				check("fill_data", fill_pattern(sel, count[`CLEAR_AW-1:0]), fill_data);
				check("core_reset", 1, core_reset);
			end
			count = count + 1;
			cycles = cycles + 1;
			@(negedge clk_sys);
		end
		if (clearing)
			report_failure("memory clear did not finish");
		check("fill count", CLEAR_WORDS, count);
		check("fill_wr after clear", 0, fill_wr);
	endtask

	task automatic backup_load_test;
		logic [31:0] r;
		logic [3:0]  ram_c;
		next_cycle();
		r = $random(seed);
		ram_c = 4'd1 + {2'b00, r[1:0]};
		opts.map_sel = 3'd0;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_has_data = 1'b0;
		begin_download(8'd0);
		write_word(`DL_ADDR_W'(0), {r[15:8], ram_c, r[7:4]});
		write_word(`DL_ADDR_W'(2), r[31:16]);
		end_download();
		wait_clear_done();
		check("ram_mask", size_mask(ram_c), cfg.ram_mask);
		last_sector = size_mask(ram_c) >> `SECTOR_SHIFT;
		bk_load = 1'b1;
		next_cycle();
		bk_load = 1'b0;
		serve_sectors(1'b1, last_sector);
	endtask

	task automatic autosave_test;
		integer cycles;
		next_cycle();
		bsram_write = 1'b1;
		next_cycle();
		bsram_write = 1'b0;
		cycles = 0;
		@(negedge clk_sys);
		while (!bk_pending && cycles < 8) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
		end
		check("pending", 1, bk_pending);
		next_cycle();
		opts.autosave = 1'b1;
		osd_open = 1'b1;
		serve_sectors(1'b0, last_sector);
		check("pending after save", 0, bk_pending);
		opts.autosave = 1'b0;
		osd_open = 1'b0;
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		seed = 27359;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		last_sector = 0;
		RESET = 1'b1;
		dl = '0;
		opts = '0;
		osd_open = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bsram_write = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_has_data = 1'b0;
		sd_ack = 1'b0;
		repeat (8)
			@(posedge clk_sys);
		#2;
		RESET = 1'b0;

		start_test("reset");
		@(negedge clk_sys);
		check("clearing", 0, clearing);
		check("fill_wr", 0, fill_wr);
		check("code_valid", 0, code_valid);
		check("sd request", 0, {sd.rd, sd.wr});
		check("busy", 0, bk_busy);
		check("pending", 0, bk_pending);
		check("core_reset", 0, core_reset);
		next_cycle();
		opts.menu_reset = 1'b1;
		@(negedge clk_sys);
		check("core_reset from menu", 1, core_reset);
		next_cycle();
		opts.menu_reset = 1'b0;
		end_test();

		start_test("header");
		repeat (3)
			header_round();
		end_test();

		start_test("cheat");
		repeat (2)
			cheat_round();
		end_test();

		start_test("clear");
		for (fill = 0; fill < 4; fill = fill + 1)
			clear_round(fill[1:0]);
		end_test();

		start_test("backup load");
		backup_load_test();
		end_test();

		start_test("autosave");
		autosave_test();
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/cart_pkg.sv
design/cart_header_detect.sv
design/cheat_code_loader.sv
design/ram_clear.sv
design/backup_ram_sync.sv
design/cart_loader_top.sv
tests/cart_loader_sva.sv
tests/cart_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cartridge loader testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module cart_loader_tb -f verilog.f -o cart_loader_sim ||
exit 1

./obj_dir/cart_loader_sim > sim.log 2>&1
cat sim.log

grep -qx "NO ERRORS" sim.log && exit 0 || exit 1
